// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;
	typedef logic [15:0] reg_list;  // LDM/STM register bitmap
	typedef logic [29:0] ptr;       // Word address
	typedef logic [4:0]  shift_amt;

	// Data-processing operations of the subset
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_ORR,
		ALU_EOR,
		ALU_MOV
	} alu_op;

	// Sequencer cycles
	typedef enum logic [2:0] {
		ISSUE,
		EXECUTE,         // ALU result, or base fetch for LDM/STM
		TRANSFER,
		BASE_WRITEBACK,
		EXCEPTION,       // R15 gets the vector
		LINK             // R14 gets the return address
	} ctrl_cycle;

	localparam reg_num R14 = 4'd14;
	localparam reg_num R15 = 4'd15;

	localparam word UNDEF_VECTOR = 32'h0000_0004;

endpackage

`default_nettype wire

// File: logic/core_decode.sv
`timescale 1ns/100ps
`default_nettype none

module core_decode (
	input  logic               clk,
	input  logic               rst_n,
	input  core_pkg::word      insn,
	input  logic               insn_valid,
	input  logic               stall,
	output logic               dec_valid,
	output core_pkg::alu_op    dec_op,
	output core_pkg::reg_num   dec_rd,
	output core_pkg::reg_num   dec_rn,
	output core_pkg::reg_num   dec_rm,
	output logic [7:0]         dec_imm,
	output logic               dec_is_imm,
	output core_pkg::shift_amt dec_shift,
	output logic               dec_ldst,
	output logic               dec_load,
	output logic               dec_wb_base,
	output core_pkg::reg_list  dec_regs,
	output logic               dec_undefined
);
	import core_pkg::*;

	logic  accept, op_ok, is_dp, is_ldm;
	alu_op dp_op;

	assign accept = insn_valid && !stall;

	always_comb begin
		op_ok = 1'b1;
		dp_op = ALU_ADD;
		case (insn[24:21])
			4'b0000: dp_op = ALU_AND;
			4'b0001: dp_op = ALU_EOR;
			4'b0010: dp_op = ALU_SUB;
			4'b0100: dp_op = ALU_ADD;
			4'b1100: dp_op = ALU_ORR;
			4'b1101: dp_op = ALU_MOV;
			default: op_ok = 1'b0;
		endcase
	end

	// Register operand only with an immediate LSL
	assign is_dp = insn[27:26] == 2'b00 && op_ok && (insn[25] || insn[6:4] == 3'b000);

	// Increment-after only, no user bank
	assign is_ldm = insn[27:25] == 3'b100 && insn[24:22] == 3'b010;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else
			dec_valid <= accept;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dec_op        <= dp_op;
			dec_rd        <= insn[15:12];
			dec_rn        <= insn[19:16];
			dec_rm        <= insn[3:0];
			dec_imm       <= insn[7:0];  // Rotation ignored
			dec_is_imm    <= insn[25];
			dec_shift     <= insn[11:7];
			dec_ldst      <= is_ldm;
			dec_load      <= insn[20];
			dec_wb_base   <= insn[21];
			dec_regs      <= insn[15:0];
			dec_undefined <= !is_dp && !is_ldm;
		end
	end

	// A fresh decode finds the sequencer free
	a_no_accept_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(dec_valid) |-> !stall);

endmodule

`default_nettype wire

// File: logic/core_ldst_pop.sv
`timescale 1ns/100ps
`default_nettype none

module core_ldst_pop (
	input  core_pkg::reg_list regs,
	output logic              valid,
	output core_pkg::reg_num  pop,
	output core_pkg::reg_list next
);
	import core_pkg::*;

	// Lowest set bit wins, so transfers go in ascending order
	always_comb begin
		valid = 1'b0;
		pop = '0;
		for (int i = 15; i >= 0; i--) begin
			if (regs[i]) begin
				valid = 1'b1;
				pop = reg_num'(i);
			end
		end
	end

	assign next = regs & (regs - 16'd1);  // Clears the popped bit

endmodule

`default_nettype wire

// File: logic/core_alu.sv
`timescale 1ns/100ps
`default_nettype none

module core_alu (
	input  core_pkg::alu_op    op,
	input  core_pkg::word      a,
	input  core_pkg::word      b,
	input  core_pkg::shift_amt shift,
	output core_pkg::word      q
);
	import core_pkg::*;

	word shifted;

	// LSL only
	assign shifted = b << shift;

	always_comb begin
		case (op)
			ALU_ADD: q = a + shifted;
			ALU_SUB: q = a - shifted;
			ALU_AND: q = a & shifted;
			ALU_ORR: q = a | shifted;
			ALU_EOR: q = a ^ shifted;
			default: q = shifted;  // MOV
		endcase
	end

endmodule

`default_nettype wire

// File: logic/core_control.sv
`timescale 1ns/100ps
`default_nettype none

module core_control (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               dec_valid,
	input  core_pkg::alu_op    dec_op,
	input  core_pkg::reg_num   dec_rd,
	input  core_pkg::reg_num   dec_rn,
	input  core_pkg::reg_num   dec_rm,
	input  logic [7:0]         dec_imm,
	input  logic               dec_is_imm,
	input  core_pkg::shift_amt dec_shift,
	input  logic               dec_ldst,
	input  logic               dec_load,
	input  logic               dec_wb_base,
	input  core_pkg::reg_list  dec_regs,
	input  logic               dec_undefined,
	output core_pkg::reg_num   ra,
	output core_pkg::reg_num   rb,
	output core_pkg::reg_num   rc,
	input  core_pkg::word      rd_value_a,
	input  core_pkg::word      rd_value_b,
	input  core_pkg::word      rd_value_c,
	output core_pkg::alu_op    alu_op_o,
	output core_pkg::word      alu_a,
	output core_pkg::word      alu_b,
	output core_pkg::shift_amt alu_shift,
	input  core_pkg::word      q_alu,
	output core_pkg::reg_list  pop_regs,
	input  logic               pop_valid,
	input  core_pkg::reg_num   pop_reg,
	input  core_pkg::reg_list  pop_next,
	output logic               stall,
	output logic               writeback,
	output core_pkg::reg_num   wr_rd,
	output core_pkg::word      wr_value,
	output logic               mem_start,
	output logic               mem_write,
	output core_pkg::ptr       mem_addr,
	output core_pkg::word      mem_data_wr,
	input  logic               mem_ready,
	input  core_pkg::word      mem_data_rd
);
	import core_pkg::*;

	ctrl_cycle cycle, next_cycle;

	logic       take, pending, busy;
	logic       is_imm_q, ldst_q, load_q, wb_base_q;
	logic [7:0] imm_q;
	logic [4:0] count;
	alu_op      op_q;
	reg_num     rd_q;
	shift_amt   shift_q;
	reg_list    list_q;
	ptr         addr_q;
	word        saved_base, pc, insn_pc;

	assign alu_op_o  = op_q;
	assign alu_a     = rd_value_a;
	assign alu_b     = is_imm_q ? {24'd0, imm_q} : rd_value_b;
	assign alu_shift = is_imm_q ? 5'd0 : shift_q;
	assign pop_regs  = list_q;
	assign rc        = pop_reg;  // Store data comes straight from the pop

	always_comb begin
		next_cycle = cycle;
		case (cycle)
			EXECUTE:   next_cycle = ldst_q ? TRANSFER : ISSUE;
			TRANSFER:
				if (!busy && !pop_valid)
					next_cycle = wb_base_q ? BASE_WRITEBACK : ISSUE;
			EXCEPTION: next_cycle = LINK;
			default:   next_cycle = ISSUE;
		endcase

		// A decoded insn that arrived mid-sequence waits in pending
		take = next_cycle == ISSUE && (dec_valid || pending);
		if (take)
			next_cycle = dec_undefined ? EXCEPTION : EXECUTE;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle     <= ISSUE;
			stall     <= 1'b0;
			pending   <= 1'b0;
			busy      <= 1'b0;
			writeback <= 1'b0;
			mem_start <= 1'b0;
			mem_write <= 1'b0;
			pc        <= '0;
		end else begin
			cycle     <= next_cycle;
			stall     <= next_cycle != ISSUE;
			pending   <= (pending || dec_valid) && !take;
			writeback <= 1'b0;
			mem_start <= 1'b0;
			if (take)
				pc <= pc + 32'd4;

			case (cycle)
				EXECUTE: writeback <= !ldst_q;
				TRANSFER: begin
					if (!busy && pop_valid) begin
						mem_start <= 1'b1;
						mem_write <= !load_q;
						busy      <= 1'b1;
					end else if (busy && mem_ready) begin
						mem_write <= 1'b0;
						busy      <= 1'b0;
						writeback <= load_q;  // Load lands one cycle after ready
					end
				end
				BASE_WRITEBACK: writeback <= 1'b1;
				EXCEPTION: begin
					writeback <= 1'b1;
					pc        <= UNDEF_VECTOR;
				end
				LINK: writeback <= 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (cycle)
			EXECUTE: begin
				wr_rd      <= rd_q;
				wr_value   <= q_alu;
				saved_base <= q_alu;  // Base + 0 for LDM/STM
				addr_q     <= q_alu[31:2];
				count      <= '0;
			end
			TRANSFER: begin
				if (!busy && pop_valid) begin
					mem_addr    <= addr_q;
					mem_data_wr <= rd_value_c;
					wr_rd       <= pop_reg;
					list_q      <= pop_next;
				end else if (busy && mem_ready) begin
					wr_value <= mem_data_rd;
					addr_q   <= addr_q + 30'd1;
					count    <= count + 5'd1;
				end
			end
			BASE_WRITEBACK: begin
				wr_rd    <= ra;
				wr_value <= saved_base + {25'd0, count, 2'b00};
			end
			EXCEPTION: begin
				wr_rd    <= R15;
				wr_value <= UNDEF_VECTOR;
			end
			LINK: begin
				wr_rd    <= R14;
				wr_value <= insn_pc + 32'd4;
			end
			default: ;
		endcase

		if (take) begin
			op_q      <= dec_ldst ? ALU_ADD : dec_op;
			imm_q     <= dec_ldst ? 8'd0 : dec_imm;
			is_imm_q  <= dec_is_imm || dec_ldst;
			shift_q   <= dec_shift;
			rd_q      <= dec_rd;
			ra        <= dec_rn;
			rb        <= dec_rm;
			ldst_q    <= dec_ldst;
			load_q    <= dec_load;
			wb_base_q <= dec_wb_base;
			list_q    <= dec_regs;
			insn_pc   <= pc;
		end
	end

	// No register write while an access is still waiting for memory
	a_no_write_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		mem_start |-> !writeback throughout (mem_ready [->1]));

	a_idle_when_free: assert property (@(posedge clk) disable iff (!rst_n)
		!stall |-> cycle == ISSUE && !busy && !pending);

endmodule

`default_nettype wire

// File: logic/core_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module core_regfile (
	input  logic             clk,
	input  logic             rst_n,
	input  core_pkg::reg_num ra,
	input  core_pkg::reg_num rb,
	input  core_pkg::reg_num rc,
	output core_pkg::word    rd_value_a,
	output core_pkg::word    rd_value_b,
	output core_pkg::word    rd_value_c,
	input  logic             writeback,
	input  core_pkg::reg_num wr_rd,
	input  core_pkg::word    wr_value
);
	import core_pkg::*;

	word regs [16];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			regs <= '{default: '0};
		else if (writeback)
			regs[wr_rd] <= wr_value;
	end

	// Forward the write in flight
	assign rd_value_a = (writeback && wr_rd == ra) ? wr_value : regs[ra];
	assign rd_value_b = (writeback && wr_rd == rb) ? wr_value : regs[rb];
	assign rd_value_c = (writeback && wr_rd == rc) ? wr_value : regs[rc];

	a_wr_rd_known: assert property (@(posedge clk) disable iff (!rst_n)
		writeback |-> !$isunknown(wr_rd));

endmodule

`default_nettype wire

// File: logic/core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top (
	input  logic             clk,
	input  logic             rst_n,
	input  core_pkg::word    insn,
	input  logic             insn_valid,
	output logic             stall,
	input  logic             mem_ready,
	input  core_pkg::word    mem_data_rd,
	output logic             mem_start,
	output logic             mem_write,
	output core_pkg::ptr     mem_addr,
	output core_pkg::word    mem_data_wr,
	output logic             writeback,
	output core_pkg::reg_num wr_rd,
	output core_pkg::word    wr_value
);
	import core_pkg::*;

	logic       dec_valid, dec_is_imm, dec_ldst, dec_load, dec_wb_base, dec_undefined;
	logic [7:0] dec_imm;
	alu_op      dec_op, alu_fn;
	reg_num     dec_rd, dec_rn, dec_rm, ra, rb, rc, pop_reg;
	shift_amt   dec_shift, alu_shift;
	reg_list    dec_regs, pop_regs, pop_next;
	word        rd_value_a, rd_value_b, rd_value_c, alu_a, alu_b, q_alu;
	logic       pop_valid;

	core_decode decode (.*);

	core_control control (
		.alu_op_o(alu_fn),
		.*
	);

	core_ldst_pop ldst_pop (
		.regs(pop_regs),
		.valid(pop_valid),
		.pop(pop_reg),
		.next(pop_next)
	);

	core_alu alu (
		.op(alu_fn),
		.a(alu_a),
		.b(alu_b),
		.shift(alu_shift),
		.q(q_alu)
	);

	core_regfile regfile (.*);

endmodule

`default_nettype wire

// File: verif/core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module core_tb;
	import core_pkg::*;

	logic   clk, rst_n, insn_valid, stall, mem_ready, mem_start, mem_write, writeback;
	word    insn, mem_data_rd, mem_data_wr, wr_value;
	ptr     mem_addr;
	reg_num wr_rd;

	word         mem [256];
	word         shadow_mem [256];
	word         shadow [16];
	word         pc_model;
	logic [35:0] wb_q [$];   // {rd, value}
	logic [62:0] acc_q [$];  // {write, word address, store data}
	logic [35:0] exp_wb;
	logic [62:0] exp_acc;
	logic        wb_avail, acc_avail, drive_dp, seen_accept;
	int          wb_done, acc_done, issued, errors, test_errors, tests_run;
	string       test_name;
	logic [3:0]  dp_opcodes [6] = '{4'b0100, 4'b0010, 4'b0000, 4'b1100, 4'b0001, 4'b1101};

	core_top UUT (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Memory answers each mem_start after 1 to 4 cycles
	always begin : memory_model
		int   lat;
		ptr   a;
		logic wr;
		word  d;
		@(posedge clk);
		if (mem_start) begin
			a = mem_addr;
			wr = mem_write;
			d = mem_data_wr;
			lat = $urandom_range(4, 1);
			repeat (lat - 1) @(posedge clk);
			@(negedge clk);
			mem_ready = 1'b1;
			mem_data_rd = mem[a[7:0]];
			if (wr)
				mem[a[7:0]] = d;
			@(negedge clk);
			mem_ready = 1'b0;
		end
	end

	always @(posedge clk) begin
		if (writeback)
			wb_done++;
		if (mem_start)
			acc_done++;
		if (insn_valid && !stall)
			seen_accept <= 1'b1;
	end

	// Expectation heads only move mid-cycle
	always @(negedge clk) begin
		wb_avail = wb_done < wb_q.size();
		acc_avail = acc_done < acc_q.size();
		if (wb_avail)
			exp_wb = wb_q[wb_done];
		if (acc_avail)
			exp_acc = acc_q[acc_done];
	end

	a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		!seen_accept |-> !(stall || writeback || mem_start || mem_write))
		else begin
			errors++;
			$display("Outputs became active before the first instruction was accepted");
		end

	a_write_expected: assert property (@(posedge clk) disable iff (!rst_n)
		writeback |-> wb_avail)
		else begin
			errors++;
			$display("%s: register write that no instruction should make", test_name);
		end

	a_write_value: assert property (@(posedge clk) disable iff (!rst_n)
		writeback && wb_avail |-> {wr_rd, wr_value} == exp_wb)
		else begin
			errors++;
			$display("FAILED %s expected %h actual %h", test_name, exp_wb,
				$sampled({wr_rd, wr_value}));
		end

	a_access_expected: assert property (@(posedge clk) disable iff (!rst_n)
		mem_start |-> acc_avail)
		else begin
			errors++;
			$display("%s: memory access that no instruction should make", test_name);
		end

	a_access_value: assert property (@(posedge clk) disable iff (!rst_n)
		mem_start && acc_avail |->
			{mem_write, mem_addr, mem_write ? mem_data_wr : 32'd0} == exp_acc)
		else begin
			errors++;
			$display("FAILED %s expected %h actual %h", test_name, exp_acc,
				$sampled({mem_write, mem_addr, mem_write ? mem_data_wr : 32'd0}));
		end

	a_dp_timing: assert property (@(posedge clk) disable iff (!rst_n)
		insn_valid && !stall && drive_dp |-> ##3 $rose(writeback) ##1 !writeback)
		else begin
			errors++;
			$display("%s: result write not two edges after accept", test_name);
		end

	function automatic word dp_result(input logic [3:0] opc, input word a, input word b);
		case (opc)
			4'b0100: return a + b;
			4'b0010: return a - b;
			4'b0000: return a & b;
			4'b1100: return a | b;
			4'b0001: return a ^ b;
			default: return b;  // MOV
		endcase
	endfunction

	function automatic reg_num any_reg();
		return reg_num'($urandom_range(13, 0));
	endfunction

	task automatic expect_write(input reg_num rd, input word value);
		wb_q.push_back({rd, value});
		shadow[rd] = value;
	endtask

	// Holds the word until an edge with stall low takes it
	task automatic issue(input word w, input logic dp);
		insn = w;
		insn_valid = 1'b1;
		drive_dp = dp;
		do
			@(posedge clk);
		while (stall);
		issued++;
		pc_model += 32'd4;
		@(negedge clk);
		insn_valid = 1'b0;
		drive_dp = 1'b0;
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (stall || writeback || wb_done != wb_q.size() || acc_done != acc_q.size())
			@(negedge clk);
	endtask

	task automatic run_dp(input logic [3:0] opc, input logic imm, input reg_num rd,
		input reg_num rn, input reg_num rm, input logic [7:0] imm8, input logic [4:0] sh);
		word op2;
		op2 = imm ? {24'd0, imm8} : shadow[rm] << sh;
		expect_write(rd, dp_result(opc, shadow[rn], op2));
		if (imm)
			issue({4'he, 3'b001, opc, 1'b0, rn, rd, 4'd0, imm8}, 1'b1);
		else
			issue({4'he, 3'b000, opc, 1'b0, rn, rd, sh, 3'b000, rm}, 1'b1);
	endtask

	task automatic random_dp();
		run_dp(dp_opcodes[$urandom_range(5, 0)], 1'($urandom), any_reg(), any_reg(),
			any_reg(), 8'($urandom), 5'($urandom));
	endtask

	task automatic run_ldst(input logic load, input logic wb, input reg_num rn,
		input reg_list list);
		word base;
		ptr  addr;
		int  n;
		base = shadow[rn];
		addr = base[31:2];
		n = 0;
		for (int r = 0; r < 16; r++) begin
			if (list[r]) begin
				if (load) begin
					acc_q.push_back({1'b0, addr, 32'd0});
					expect_write(reg_num'(r), shadow_mem[addr[7:0]]);
				end else begin
					acc_q.push_back({1'b1, addr, shadow[r]});
					shadow_mem[addr[7:0]] = shadow[r];
				end
				addr++;
				n++;
			end
		end
		if (wb)
			expect_write(rn, base + 32'(4 * n));
		issue({4'he, 3'b100, 2'b01, 1'b0, wb, load, rn, list}, 1'b0);
	endtask

	task automatic run_undef();
		expect_write(4'd15, 32'h0000_0004);
		expect_write(4'd14, pc_model + 32'd4);
		issue({4'he, 3'b011, 20'($urandom), 1'b1, 4'($urandom)}, 1'b0);
		pc_model = 32'h0000_0004;  // Fetch resumes at the vector
	endtask

	task automatic end_test();
		tests_run++;
		$display("%s finished with %0d errors", test_name, errors - test_errors);
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < 40 * issued + 200) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout, the DUT stopped making progress");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin : stimulus
		reg_num  rn;
		reg_list list;
		void'($urandom(32'h65e4_0ccb));
		rst_n = 1'b0;
		insn = '0;
		insn_valid = 1'b0;
		drive_dp = 1'b0;
		seen_accept = 1'b0;
		mem_ready = 1'b0;
		mem_data_rd = '0;
		pc_model = '0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = $urandom;
			shadow_mem[i] = mem[i];
		end
		for (int i = 0; i < 16; i++)
			shadow[i] = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_name = "reset_idle";
		test_errors = errors;
		repeat (6) @(negedge clk);
		run_dp(4'b0100, 1'b1, 4'd0, 4'd14, 4'd0, 8'd0, 5'd0);  // R14 still zero
		wait_idle();
		end_test();

		test_name = "dp_ops";
		test_errors = errors;
		for (int r = 0; r < 14; r++) begin
			run_dp(4'b1101, 1'b1, reg_num'(r), 4'd0, 4'd0, 8'($urandom), 5'd0);
			wait_idle();
		end
		repeat (40) begin
			random_dp();
			wait_idle();
		end
		end_test();

		for (int t = 0; t < 2; t++) begin
			test_name = t == 0 ? "ldm" : "stm";
			test_errors = errors;
			for (int i = 0; i < 6; i++) begin
				rn = any_reg();
				run_dp(4'b1101, 1'b1, rn, 4'd0, 4'd0, 8'($urandom_range(48, 0) * 4), 5'd0);
				wait_idle();
				list = 16'($urandom) & 16'h3fff & ~(16'd1 << rn);
				if (t == 1 && i == 5)
					list = '0;
				run_ldst(t == 0, 1'($urandom), rn, list);
				wait_idle();
			end
			for (int i = 0; i < 256; i++)
				assert (mem[i] === shadow_mem[i]) else begin
					errors++;
					$display("FAILED %s expected %h actual %h", test_name, shadow_mem[i], mem[i]);
				end
			end_test();
		end

		test_name = "undef";
		test_errors = errors;
		run_undef();
		wait_idle();
		random_dp();
		wait_idle();
		run_undef();  // Link shows the PC continued from the vector
		wait_idle();
		end_test();

		test_name = "backpressure";
		test_errors = errors;
		run_dp(4'b1101, 1'b1, 4'd2, 4'd0, 4'd0, 8'h40, 5'd0);
		wait_idle();
		run_ldst(1'b1, 1'b1, 4'd2, (16'($urandom) & 16'h3ffb) | 16'h0003);
		while (!stall)
			@(negedge clk);
		random_dp();
		wait_idle();
		end_test();

		$display("%0d tests, %0d register writes, %0d memory accesses, %0d errors",
			tests_run, wb_done, acc_done, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
logic/core_pkg.sv
logic/core_decode.sv
logic/core_ldst_pop.sv
logic/core_alu.sv
logic/core_control.sv
logic/core_regfile.sv
logic/core_top.sv
verif/core_tb.sv
